/* hdl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    // ****************************************
    // csr addresses
    // ****************************************
    localparam logic [11:0] csr_mvendorid     = 12'hf11;
    localparam logic [11:0] csr_marchid       = 12'hf12;
    localparam logic [11:0] csr_mimpid        = 12'hf13;
    localparam logic [11:0] csr_mhartid       = 12'hf14;
    localparam logic [11:0] csr_mstatus       = 12'h300;
    localparam logic [11:0] csr_misa          = 12'h301;
    localparam logic [11:0] csr_mie           = 12'h304;
    localparam logic [11:0] csr_mtvec         = 12'h305;
    localparam logic [11:0] csr_mcounteren    = 12'h306;
    localparam logic [11:0] csr_mcountinhibit = 12'h320;
    localparam logic [11:0] csr_mscratch      = 12'h340;
    localparam logic [11:0] csr_mepc          = 12'h341;
    localparam logic [11:0] csr_mcause        = 12'h342;
    localparam logic [11:0] csr_mtval         = 12'h343;
    localparam logic [11:0] csr_mip           = 12'h344;
    localparam logic [11:0] csr_mcycle        = 12'hb00;
    localparam logic [11:0] csr_minstret      = 12'hb02;
    localparam logic [11:0] csr_mcycleh       = 12'hb80;
    localparam logic [11:0] csr_minstreth     = 12'hb82;

    localparam logic [1:0] m_mode = 2'd3;
    localparam logic [1:0] u_mode = 2'd0;

    // ****************************************
    // causes, also the mie and mip bit positions
    // ****************************************
    localparam logic [3:0] cause_illegal         = 4'd2;
    localparam logic [3:0] cause_ecall_u         = 4'd8;
    localparam logic [3:0] cause_ecall_m         = 4'd11;
    localparam logic [3:0] interrupt_mach_soft   = 4'd3;
    localparam logic [3:0] interrupt_mach_timer  = 4'd7;
    localparam logic [3:0] interrupt_mach_extern = 4'd11;

    localparam logic [31:0] misa_value = 32'h4010_0100;  // rv32 with i and u.

    localparam int mstatus_mie  = 3;
    localparam int mstatus_mpie = 7;
    localparam int mstatus_mpp  = 11;  // two bits, 12:11.

    localparam logic [6:0] op_system    = 7'b1110011;
    localparam logic [2:0] f3_priv      = 3'b000;
    localparam logic [1:0] csr_op_write = 2'b01;
    localparam logic [1:0] csr_op_set   = 2'b10;
    localparam logic [1:0] csr_op_clear = 2'b11;
    localparam logic [6:0] funct7_mret  = 7'b0011000;
    localparam logic [4:0] rs2_mret     = 5'b00010;

    typedef struct packed {
        logic [11:0] csr;
        logic [4:0]  rs1;   // or uimm.
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } csr_form_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } priv_form_t;

    // funct12 of mret and ecall sits in the csr field.
    typedef union packed {
        csr_form_t  csr_form;
        priv_form_t priv_form;
    } instr_word_t;

endpackage

`default_nettype wire

/* hdl/csr_access.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_access (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 instr_valid,
    input  csr_pkg::instr_word_t instr,
    input  logic [31:0]          pc,
    input  logic [31:0]          rs1_value,
    input  logic                 exception_in,
    input  logic [3:0]           ecause_in,
    input  logic [31:0]          etval_in,
    input  logic [31:0]          read_data,
    input  logic [1:0]           mode,
    output logic [11:0]          read_addr,
    output logic                 write_enable,
    output logic [11:0]          write_addr,
    output logic [31:0]          write_data,
    output logic                 retire,
    output logic                 exception,
    output logic [3:0]           ecause,
    output logic [31:0]          epc,
    output logic [31:0]          etval,
    output logic                 mret_request,
    output logic                 rd_request,
    output logic [4:0]           rd_index,
    output logic [31:0]          rd_value
);
    import csr_pkg::*;

    logic [1:0]  squash_pipe;  // trap or mret until redirect.
    logic        squash;
    logic        live;
    logic [2:0]  funct3;
    logic        is_system;
    logic        is_csr;
    logic        is_ecall;
    logic        is_mret;
    logic        illegal;
    logic        own_exception;
    logic [31:0] source;

    assign squash    = |squash_pipe;
    assign live      = instr_valid && !squash;
    assign funct3    = instr.csr_form.funct3;
    assign is_system = instr.csr_form.opcode == op_system;
    assign is_csr    = is_system && funct3[1:0] != 2'b00;
    assign is_mret   = is_system && funct3 == f3_priv &&
                       instr.priv_form.funct7 == funct7_mret && instr.priv_form.rs2 == rs2_mret;
    assign is_ecall  = is_system && funct3 == f3_priv &&
                       instr.priv_form.funct7 == 7'd0 && instr.priv_form.rs2 == 5'd0;

    // machine csrs and mret need m mode.
    assign illegal = mode == u_mode &&
                     ((is_csr && instr.csr_form.csr[9:8] == 2'b11) || is_mret);
    assign own_exception = live && (illegal || is_ecall);
    assign exception     = own_exception || (exception_in && !squash);

    always_comb begin
        if (exception_in) begin
            ecause = ecause_in;  // earlier stage wins.
            etval  = etval_in;
        end else if (illegal) begin
            ecause = cause_illegal;
            etval  = instr;
        end else begin
            ecause = (mode == u_mode) ? cause_ecall_u : cause_ecall_m;
            etval  = '0;
        end
    end

    assign source = funct3[2] ? {27'd0, instr.csr_form.rs1} : rs1_value;

    always_comb begin
        case (funct3[1:0])
            csr_op_set:   write_data = read_data | source;
            csr_op_clear: write_data = read_data & ~source;
            default:      write_data = source;
        endcase
    end

    assign read_addr    = instr.csr_form.csr;
    assign write_addr   = instr.csr_form.csr;
    assign write_enable = live && is_csr && !exception &&
                          (funct3[1:0] == csr_op_write || instr.csr_form.rs1 != 5'd0);
    assign rd_request   = live && is_csr && !exception &&
                          !(funct3[1:0] == csr_op_write && instr.csr_form.rd == 5'd0);
    assign rd_index     = instr.csr_form.rd;
    assign rd_value     = read_data;  // old value.
    assign retire       = live && !exception;
    assign mret_request = live && is_mret && !exception;
    assign epc          = pc;

    always_ff @(posedge clock) begin
        if (!reset) begin
            squash_pipe <= 2'b00;
        end else begin
            squash_pipe <= {squash_pipe[0], exception || mret_request};
        end
    end

endmodule

`default_nettype wire

/* hdl/csr_file.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_file #(
    parameter logic [31:0] HART_ID = 32'd0
) (
    input  logic        clock,
    input  logic        reset,
    input  logic [11:0] read_addr,
    input  logic        write_enable,
    input  logic [11:0] write_addr,
    input  logic [31:0] write_data,
    input  logic        retire,
    input  logic        exception,
    input  logic [3:0]  ecause,
    input  logic [31:0] epc,
    input  logic [31:0] etval,
    input  logic        mret_request,
    input  logic        meip,
    input  logic        mtip,
    input  logic        msip,
    output logic [31:0] read_data,
    output logic [1:0]  mode,
    output logic        trap,
    output logic        mret,
    output logic [31:0] trap_vector,
    output logic [31:0] mepc
);
    import csr_pkg::*;

    logic        status_mie;
    logic        status_mpie;
    logic [1:0]  status_mpp;
    logic        enable_meie;
    logic        enable_mtie;
    logic        enable_msie;
    logic        pending_meip;
    logic        pending_mtip;
    logic        pending_msip;
    logic [31:0] mtvec;
    logic [31:0] mscratch;
    logic [31:0] mcause;
    logic [31:0] mtval;
    logic [63:0] mcycle;
    logic [63:0] minstret;
    logic [31:0] mcounteren;
    logic [31:0] mcountinhibit;
    logic [31:0] status_word;
    logic [31:0] enable_word;
    logic [31:0] pending_word;
    logic        take_interrupt;
    logic        take_trap;
    logic [3:0]  interrupt_code;

    always_comb begin
        status_word                       = '0;
        status_word[mstatus_mie]          = status_mie;
        status_word[mstatus_mpie]         = status_mpie;
        status_word[mstatus_mpp +: 2]     = status_mpp;
        enable_word                       = '0;
        enable_word[interrupt_mach_soft]  = enable_msie;
        enable_word[interrupt_mach_timer] = enable_mtie;
        enable_word[interrupt_mach_extern] = enable_meie;
        pending_word                       = '0;
        pending_word[interrupt_mach_soft]  = pending_msip;
        pending_word[interrupt_mach_timer] = pending_mtip;
        pending_word[interrupt_mach_extern] = pending_meip;
    end

    // ****************************************
    // read port
    // ****************************************
    always_comb begin
        case (read_addr)
            csr_misa:          read_data = misa_value;
            csr_mhartid:       read_data = HART_ID;
            csr_mstatus:       read_data = status_word;
            csr_mie:           read_data = enable_word;
            csr_mip:           read_data = pending_word;
            csr_mtvec:         read_data = mtvec;
            csr_mscratch:      read_data = mscratch;
            csr_mepc:          read_data = mepc;
            csr_mcause:        read_data = mcause;
            csr_mtval:         read_data = mtval;
            csr_mcycle:        read_data = mcycle[31:0];
            csr_mcycleh:       read_data = mcycle[63:32];
            csr_minstret:      read_data = minstret[31:0];
            csr_minstreth:     read_data = minstret[63:32];
            csr_mcounteren:    read_data = mcounteren;
            csr_mcountinhibit: read_data = mcountinhibit;
            default:           read_data = '0;  // id registers read zero.
        endcase
    end

    // ****************************************
    // interrupt selection
    // ****************************************
    always_comb begin
        interrupt_code = interrupt_mach_soft;
        if (enable_meie && pending_meip) begin
            interrupt_code = interrupt_mach_extern;
        end else if (enable_mtie && pending_mtip) begin
            interrupt_code = interrupt_mach_timer;
        end
    end

    assign take_interrupt = retire && status_mie && |(enable_word & pending_word);
    assign take_trap      = exception || take_interrupt;

    assign trap_vector = (mtvec[1:0] == 2'b01 && mcause[31]) ?
                         {mtvec[31:2] + {26'd0, mcause[3:0]}, 2'b00} :
                         {mtvec[31:2], 2'b00};

    always_ff @(posedge clock) begin
        if (!reset) begin
            mode          <= m_mode;
            status_mie    <= 1'b0;
            status_mpie   <= 1'b0;
            status_mpp    <= u_mode;
            enable_meie   <= 1'b0;
            enable_mtie   <= 1'b0;
            enable_msie   <= 1'b0;
            pending_meip  <= 1'b0;
            pending_mtip  <= 1'b0;
            pending_msip  <= 1'b0;
            mcause        <= '0;
            mcycle        <= '0;
            minstret      <= '0;
            mcounteren    <= '0;
            mcountinhibit <= '0;
            trap          <= 1'b0;
            mret          <= 1'b0;
        end else begin
            pending_meip <= meip;
            pending_mtip <= mtip;
            pending_msip <= msip;
            if (!mcountinhibit[0]) begin
                mcycle <= mcycle + 64'd1;
            end
            if (retire && !mcountinhibit[2]) begin
                minstret <= minstret + 64'd1;
            end

            if (write_enable) begin
                case (write_addr)
                    csr_mstatus: begin
                        status_mie  <= write_data[mstatus_mie];
                        status_mpie <= write_data[mstatus_mpie];
                        if (write_data[mstatus_mpp +: 2] == m_mode ||
                            write_data[mstatus_mpp +: 2] == u_mode) begin
                            status_mpp <= write_data[mstatus_mpp +: 2];
                        end
                    end
                    csr_mie: begin
                        enable_meie <= write_data[interrupt_mach_extern];
                        enable_mtie <= write_data[interrupt_mach_timer];
                        enable_msie <= write_data[interrupt_mach_soft];
                    end
                    csr_mcause:        mcause <= write_data;
                    csr_mcycle:        mcycle[31:0] <= write_data;
                    csr_mcycleh:       mcycle[63:32] <= write_data;
                    csr_minstret:      minstret[31:0] <= write_data;
                    csr_minstreth:     minstret[63:32] <= write_data;
                    csr_mcounteren:    mcounteren <= write_data;
                    csr_mcountinhibit: mcountinhibit <= write_data;
                    default: ;
                endcase
            end

            trap <= take_trap;
            mret <= mret_request;
            if (take_trap) begin
                status_mpie <= status_mie;
                status_mie  <= 1'b0;
                status_mpp  <= mode;
                mode        <= m_mode;
                mcause      <= exception ? {28'd0, ecause} : {1'b1, 27'd0, interrupt_code};
            end else if (mret_request) begin
                status_mie  <= status_mpie;
                status_mpie <= 1'b1;
                mode        <= status_mpp;
                status_mpp  <= u_mode;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_enable) begin
            case (write_addr)
                csr_mtvec:    mtvec <= {write_data[31:2], 1'b0, write_data[0]};
                csr_mscratch: mscratch <= write_data;
                csr_mepc:     mepc <= {write_data[31:2], 2'b00};
                csr_mtval:    mtval <= write_data;
                default: ;
            endcase
        end
        if (exception) begin
            mepc  <= epc;
            mtval <= etval;
        end else if (take_interrupt) begin
            mepc  <= epc + 32'd4;  // interrupted instruction has retired.
            mtval <= '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/trap_redirect.sv */
`timescale 1ns/1ns
`default_nettype none

module trap_redirect (
    input  logic        clock,
    input  logic        reset,
    input  logic        trap,
    input  logic        mret,
    input  logic [31:0] trap_vector,
    input  logic [31:0] mepc,
    input  logic        rd_request,
    input  logic [4:0]  rd_index,
    input  logic [31:0] rd_value,
    output logic        rd_write,
    output logic [4:0]  rd_index_out,
    output logic [31:0] rd_data,
    output logic        redirect,
    output logic [31:0] redirect_pc
);

    always_ff @(posedge clock) begin
        if (!reset) begin
            rd_write <= 1'b0;
            redirect <= 1'b0;
        end else begin
            rd_write <= rd_request;
            redirect <= trap || mret;
        end
    end

    always_ff @(posedge clock) begin
        rd_index_out <= rd_index;
        rd_data      <= rd_value;
        if (trap) begin
            redirect_pc <= trap_vector;
        end else if (mret) begin
            redirect_pc <= mepc;  // return address.
        end
    end

endmodule

`default_nettype wire

/* hdl/csr_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_unit #(
    parameter logic [31:0] HART_ID = 32'd0
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 instr_valid,
    input  csr_pkg::instr_word_t instr,
    input  logic [31:0]          pc,
    input  logic [31:0]          rs1_value,
    input  logic                 exception,
    input  logic [3:0]           ecause,
    input  logic [31:0]          etval,
    input  logic                 meip,
    input  logic                 mtip,
    input  logic                 msip,
    output logic                 rd_write,
    output logic [4:0]           rd_index,
    output logic [31:0]          rd_data,
    output logic                 redirect,
    output logic [31:0]          redirect_pc,
    output logic [1:0]           mode
);

    logic [11:0] read_addr;
    logic [31:0] read_data;
    logic        write_enable;
    logic [11:0] write_addr;
    logic [31:0] write_data;
    logic        retire;
    logic        trap_exception;  // merged with the decoder's own.
    logic [3:0]  trap_cause;
    logic [31:0] trap_epc;
    logic [31:0] trap_tval;
    logic        mret_request;
    logic        trap;
    logic        mret;
    logic [31:0] trap_vector;
    logic [31:0] mepc;
    logic        rd_request;
    logic [4:0]  access_rd_index;
    logic [31:0] rd_value;

    csr_access u_access (
        .clock        (clock),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pc           (pc),
        .rs1_value    (rs1_value),
        .exception_in (exception),
        .ecause_in    (ecause),
        .etval_in     (etval),
        .read_data    (read_data),
        .mode         (mode),
        .read_addr    (read_addr),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .retire       (retire),
        .exception    (trap_exception),
        .ecause       (trap_cause),
        .epc          (trap_epc),
        .etval        (trap_tval),
        .mret_request (mret_request),
        .rd_request   (rd_request),
        .rd_index     (access_rd_index),
        .rd_value     (rd_value)
    );

    csr_file #(
        .HART_ID (HART_ID)
    ) u_file (
        .clock        (clock),
        .reset        (reset),
        .read_addr    (read_addr),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .retire       (retire),
        .exception    (trap_exception),
        .ecause       (trap_cause),
        .epc          (trap_epc),
        .etval        (trap_tval),
        .mret_request (mret_request),
        .meip         (meip),
        .mtip         (mtip),
        .msip         (msip),
        .read_data    (read_data),
        .mode         (mode),
        .trap         (trap),
        .mret         (mret),
        .trap_vector  (trap_vector),
        .mepc         (mepc)
    );

    trap_redirect u_redirect (
        .clock        (clock),
        .reset        (reset),
        .trap         (trap),
        .mret         (mret),
        .trap_vector  (trap_vector),
        .mepc         (mepc),
        .rd_request   (rd_request),
        .rd_index     (access_rd_index),
        .rd_value     (rd_value),
        .rd_write     (rd_write),
        .rd_index_out (rd_index),
        .rd_data      (rd_data),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

endmodule

`default_nettype wire

/* bench/csr_unit_props.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_unit_props (
    input logic        clock,
    input logic        reset,
    input logic        rd_write,
    input logic        redirect,
    input logic [31:0] redirect_pc,
    input logic [1:0]  mode
);
    import csr_pkg::*;

    // ****************************************
    // reset behavior
    // ****************************************
    outputs_low_in_reset: assert property (@(posedge clock)
        !reset |=> !redirect && !rd_write)
        else $error("redirect or rd_write high during reset");

    // ****************************************
    // redirect and mode
    // ****************************************
    redirect_one_cycle: assert property (@(posedge clock) disable iff (!reset)
        redirect |=> !redirect)
        else $error("redirect held for more than one cycle");

    redirect_word_aligned: assert property (@(posedge clock) disable iff (!reset)
        redirect |-> redirect_pc[1:0] == 2'b00)
        else $error("redirect target not word aligned");

    mode_m_or_u: assert property (@(posedge clock) disable iff (!reset)
        mode == m_mode || mode == u_mode)
        else $error("privilege mode neither m nor u");

endmodule

bind csr_unit csr_unit_props u_props (
    .clock       (clock),
    .reset       (reset),
    .rd_write    (rd_write),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .mode        (mode)
);

`default_nettype wire

/* bench/csr_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_unit_tb;
    import csr_pkg::*;

    logic        clock = 1'b0;
    logic        reset;
    logic        instr_valid;
    instr_word_t instr;
    logic [31:0] pc;
    logic [31:0] rs1_value;
    logic        exception;
    logic [3:0]  ecause;
    logic [31:0] etval;
    logic        meip;
    logic        mtip;
    logic        msip;
    logic        rd_write;
    logic [4:0]  rd_index;
    logic [31:0] rd_data;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic [1:0]  mode;

    int          errors;
    int          checks;
    int          redirect_errors = 0;
    int          cycle_count = 0;
    int          start_cycle;
    logic [31:0] lfsr_state;
    logic [31:0] redirect_target;
    logic [4:0]  issued_rd;
    logic [31:0] value;
    logic [31:0] mask;
    logic [31:0] base;
    logic [31:0] target;
    logic [31:0] word;
    logic [31:0] first;
    logic [31:0] second;
    logic [31:0] elapsed;
    logic [31:0] count;

    csr_unit #(
        .HART_ID (32'd5)
    ) DUT (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_value   (rs1_value),
        .exception   (exception),
        .ecause      (ecause),
        .etval       (etval),
        .meip        (meip),
        .mtip        (mtip),
        .msip        (msip),
        .rd_write    (rd_write),
        .rd_index    (rd_index),
        .rd_data     (rd_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mode        (mode)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    redirect_target_check: assert property (@(posedge clock) disable iff (!reset)
        redirect |-> redirect_pc == redirect_target)
        else begin
            redirect_errors++;
            $display("ERR %0t redirect_pc got %h expected %h", $time, $sampled(redirect_pc),
                     redirect_target);
        end

    // one lfsr step per bit taken.
    function automatic logic [31:0] random_bits(input int bits);
        logic [31:0] result;
        logic        feedback;
        int          i;
        result = '0;
        for (i = 0; i < bits; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            result     = {result[30:0], feedback};
        end
        return result;
    endfunction

    function automatic logic [31:0] csr_op(input logic [2:0] funct3, input logic [11:0] addr,
                                           input logic [4:0] rs1, input logic [4:0] rd);
        return {addr, rs1, funct3, rd, 7'b1110011};
    endfunction

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic issue(input logic [31:0] word_in, input logic [31:0] source,
                         input logic [31:0] at_pc);
        instr       = word_in;
        rs1_value   = source;
        pc          = at_pc;
        issued_rd   = word_in[11:7];
        instr_valid = 1'b1;
        @(negedge clock);
        instr_valid = 1'b0;
        exception   = 1'b0;
    endtask

    task automatic wait_writeback(output logic [31:0] data);
        int waited;
        waited = 0;
        while (!rd_write && waited < 8) begin
            @(negedge clock);
            waited++;
        end
        if (!rd_write) begin
            errors++;
            $display("timed out waiting for a register writeback at %0t", $time);
        end else begin
            check("rd_index", {27'd0, rd_index}, {27'd0, issued_rd});
        end
        data = rd_data;
    endtask

    task automatic wait_redirect();
        int waited;
        waited = 0;
        while (!redirect && waited < 8) begin
            @(negedge clock);
            waited++;
        end
        if (!redirect) begin
            errors++;
            $display("timed out waiting for a redirect at %0t", $time);
        end
        @(negedge clock);  // instruction after a trap is dropped.
    endtask

    task automatic read_value(input logic [11:0] addr, output logic [31:0] data);
        issue(csr_op(3'b010, addr, 5'd0, 5'd1), 32'd0, pc);
        wait_writeback(data);
    endtask

    task automatic read_csr(input logic [11:0] addr, input logic [31:0] expected,
                            input string name);
        logic [31:0] data;
        read_value(addr, data);
        check(name, data, expected);
    endtask

    initial begin
        reset           = 1'b0;
        instr_valid     = 1'b0;
        instr           = '0;
        pc              = 32'h0000_0100;
        rs1_value       = '0;
        exception       = 1'b0;
        ecause          = '0;
        etval           = '0;
        meip            = 1'b0;
        mtip            = 1'b0;
        msip            = 1'b0;
        errors          = 0;
        checks          = 0;
        lfsr_state      = 32'hf9e4;
        redirect_target = '0;
        issued_rd       = '0;
        repeat (5) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);

        // ****************************************
        // read and write of mscratch
        // ****************************************
        value = random_bits(32);
        issue(csr_op(3'b001, csr_mscratch, 5'd2, 5'd0), value, pc);
        mask = random_bits(32);
        issue(csr_op(3'b010, csr_mscratch, 5'd3, 5'd11), mask, pc);
        wait_writeback(word);
        check("rd_data (csrrs)", word, value);
        value = value | mask;
        mask  = random_bits(32);
        issue(csr_op(3'b011, csr_mscratch, 5'd4, 5'd12), mask, pc);
        wait_writeback(word);
        check("rd_data (csrrc)", word, value);
        value = value & ~mask;
        issue(csr_op(3'b010, csr_mscratch, 5'd0, 5'd13), 32'd0, pc);  // zero source.
        wait_writeback(word);
        check("rd_data (csrrs x0)", word, value);
        issue(csr_op(3'b111, csr_mscratch, 5'd0, 5'd14), 32'd0, pc);
        wait_writeback(word);
        check("rd_data (csrrci 0)", word, value);
        mask = random_bits(5);
        issue(csr_op(3'b110, csr_mscratch, mask[4:0], 5'd15), 32'd0, pc);
        wait_writeback(word);
        check("rd_data (csrrsi)", word, value);
        read_csr(csr_mscratch, value | mask, "rd_data (mscratch)");

        // ****************************************
        // constants and counters
        // ****************************************
        read_csr(csr_mhartid, 32'd5, "rd_data (mhartid)");
        read_csr(csr_misa, misa_value, "rd_data (misa)");
        start_cycle = cycle_count;
        read_value(csr_mcycle, first);
        repeat (2 + random_bits(3)) @(negedge clock);
        elapsed = cycle_count - start_cycle;
        read_value(csr_mcycle, second);
        checks++;
        assert (second - first >= elapsed) else begin
            errors++;
            $display("ERR %0t rd_data (mcycle) advanced %0d expected at least %0d", $time,
                     second - first, elapsed);
        end
        issue(csr_op(3'b110, csr_mcountinhibit, 5'd1, 5'd0), 32'd0, pc);
        read_value(csr_mcycle, first);
        repeat (3) @(negedge clock);
        read_csr(csr_mcycle, first, "rd_data (inhibited mcycle)");
        issue(csr_op(3'b111, csr_mcountinhibit, 5'd1, 5'd0), 32'd0, pc);
        read_value(csr_minstret, first);
        count = 1 + random_bits(3);
        repeat (count) issue(csr_op(3'b010, csr_mscratch, 5'd0, 5'd0), 32'd0, pc);
        read_csr(csr_minstret, first + count + 1, "rd_data (minstret)");

        // ****************************************
        // ecall in m mode
        // ****************************************
        base = random_bits(30) << 2;
        issue(csr_op(3'b001, csr_mtvec, 5'd5, 5'd0), base, pc);
        target          = random_bits(30) << 2;
        redirect_target = base;
        issue(32'h0000_0073, 32'd0, target);  // ecall.
        wait_redirect();
        read_csr(csr_mcause, 32'd11, "rd_data (mcause)");
        read_csr(csr_mepc, target, "rd_data (mepc)");

        // vectored timer interrupt.
        issue(csr_op(3'b001, csr_mtvec, 5'd5, 5'd0), base | 32'd1, pc);
        issue(csr_op(3'b010, csr_mie, 5'd6, 5'd0), 32'h0000_0080, pc);
        issue(csr_op(3'b010, csr_mstatus, 5'd7, 5'd0), 32'h0000_0008, pc);
        mtip = 1'b1;
        repeat (2) @(negedge clock);
        redirect_target = base + 32'd28;
        issue(csr_op(3'b010, csr_mscratch, 5'd0, 5'd0), 32'd0, pc);
        wait_redirect();
        mtip = 1'b0;
        read_csr(csr_mcause, 32'h8000_0007, "rd_data (mcause)");
        read_value(csr_mstatus, word);
        check("rd_data (mstatus.mie)", {31'd0, word[3]}, 32'd0);

        // ****************************************
        // mret into u mode, then an illegal access
        // ****************************************
        issue(csr_op(3'b011, csr_mstatus, 5'd8, 5'd0), 32'h0000_1800, pc);
        target = random_bits(30) << 2;
        issue(csr_op(3'b001, csr_mepc, 5'd9, 5'd0), target, pc);
        redirect_target = target;
        issue(32'h3020_0073, 32'd0, pc);  // mret.
        wait_redirect();
        check("mode", {30'd0, mode}, {30'd0, u_mode});
        word            = random_bits(30) << 2;
        value           = csr_op(3'b010, csr_mscratch, 5'd0, 5'd1);
        redirect_target = base;
        issue(value, 32'd0, word);
        wait_redirect();
        check("mode", {30'd0, mode}, {30'd0, m_mode});
        read_csr(csr_mcause, 32'd2, "rd_data (mcause)");
        read_csr(csr_mepc, word, "rd_data (mepc)");
        read_csr(csr_mtval, value, "rd_data (mtval)");

        // external exception beats a pending meip.
        issue(csr_op(3'b010, csr_mie, 5'd10, 5'd0), 32'h0000_0800, pc);
        issue(csr_op(3'b010, csr_mstatus, 5'd11, 5'd0), 32'h0000_0008, pc);
        meip = 1'b1;
        repeat (2) @(negedge clock);
        word            = random_bits(4);
        exception       = 1'b1;
        ecause          = word[3:0];
        etval           = random_bits(32);
        redirect_target = base;
        issue(csr_op(3'b010, csr_mscratch, 5'd0, 5'd0), 32'd0, pc);
        wait_redirect();
        meip = 1'b0;
        read_csr(csr_mcause, {28'd0, ecause}, "rd_data (mcause)");
        read_csr(csr_mtval, etval, "rd_data (mtval)");

        repeat (2) @(negedge clock);
        $display("checks %0d, errors %0d, redirect errors %0d", checks, errors,
                 redirect_errors);
        if (errors == 0 && redirect_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* csr_unit.f */
hdl/csr_pkg.sv
hdl/csr_access.sv
hdl/csr_file.sv
hdl/trap_redirect.sv
hdl/csr_unit.sv
bench/csr_unit_props.sv
bench/csr_unit_tb.sv

/* Makefile */
TOP = csr_unit_tb

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -f csr_unit.f -o $(TOP)
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir
